/* hdl/isect_macros.svh */
// --------------------------------------------------------------------------
// Q8.8 fixed point throughout. The math pipeline is written for a depth of 4
// --------------------------------------------------------------------------
`ifndef ISECT_MACROS_SVH
`define ISECT_MACROS_SVH

// Scalar format
`define ISECT_FIXW 16
`define ISECT_FRAC 8

// Minimum distance, in Q8.8 (4/256)
`define ISECT_EPS 4

// Transform and intersection stages
`define ISECT_MATH_LAT 4

// Output queues, power of two depth
`define ISECT_QDEPTH 16

// Credits granted by each downstream unit at reset
`define ISECT_CREDITS 4

// Bookkeeping field widths
`define ISECT_IDW 12
`define ISECT_RAYW 8

`endif

/* hdl/isect_geom_pkg.sv */
// --------------------------------------------------------------------------
// Products and their sums are kept in 40 bits so no partial result wraps
// --------------------------------------------------------------------------
`default_nettype none

`include "isect_macros.svh"

package isect_geom_pkg;

  // Signed Q8.8
  typedef logic signed [`ISECT_FIXW-1:0] fix_t;

  localparam int WIDE_W = 40;

  // Accumulator for products of two fix_t values
  typedef logic signed [WIDE_W-1:0] wide_t;

  typedef struct packed {
    fix_t x;
    fix_t y;
    fix_t z;
  } vec3_t;

  // One row of the world to unit-triangle transform
  typedef struct packed {
    fix_t m0;
    fix_t m1;
    fix_t m2;
    fix_t translate;
  } xform_row_t;

  typedef struct packed {
    xform_row_t r0;
    xform_row_t r1;
    xform_row_t r2;
  } tri_xform_t;

  typedef struct packed {
    vec3_t origin;
    vec3_t dir;
  } ray_t;

endpackage

`default_nettype wire

/* hdl/isect_flow_pkg.sv */
// --------------------------------------------------------------------------
// Leaf counters are 8 bits, so a leaf holds at most 255 triangles
// --------------------------------------------------------------------------
`default_nettype none

`include "isect_macros.svh"

package isect_flow_pkg;

  import isect_geom_pkg::*;

  typedef logic [`ISECT_RAYW-1:0] ray_info_t;
  typedef logic [`ISECT_IDW-1:0]  tri_id_t;

  typedef struct packed {
    logic [7:0] lnum_left;
    logic [7:0] lindex;
  } leaf_cnt_t;

  // From the triangle cache, counters as read from the leaf
  typedef struct packed {
    ray_info_t  ray_info;
    tri_id_t    tri_id;
    leaf_cnt_t  leaf_cnt;
    tri_xform_t tri_xform;
    ray_t       ray;
  } icache_to_isect_t;

  // Same item after the leaf counters have been stepped
  typedef struct packed {
    ray_info_t  ray_info;
    tri_id_t    tri_id;
    leaf_cnt_t  leaf_cnt;
    tri_xform_t tri_xform;
    ray_t       ray;
  } isect_job_t;

  // Distance is t_num / t_den, barycentrics share the denominator
  typedef struct packed {
    ray_info_t ray_info;
    tri_id_t   tri_id;
    logic      hit;
    logic      is_last;
    fix_t      t_num;
    fix_t      t_den;
    wide_t     u_num;
    wide_t     v_num;
  } list_msg_t;

  // Fetch request for the next triangle of the leaf
  typedef struct packed {
    ray_info_t ray_info;
    leaf_cnt_t leaf_cnt;
  } leaf_msg_t;

endpackage

`default_nettype wire

/* hdl/isect_issue.sv */
// --------------------------------------------------------------------------
// Accepts an item only with a slot reserved in both output queues
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "isect_macros.svh"

module isect_issue
  import isect_flow_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  input  icache_to_isect_t in_data,
  output logic             in_ready,
  input  logic             list_slot_free,
  input  logic             leaf_slot_free,
  output logic             job_valid,
  output isect_job_t       job_data
);

  localparam int CW = $clog2(`ISECT_QDEPTH) + 1;

  logic [CW-1:0] list_resv;
  logic [CW-1:0] leaf_resv;
  logic          accept;

  assign in_ready = (list_resv < CW'(`ISECT_QDEPTH)) && (leaf_resv < CW'(`ISECT_QDEPTH));
  assign accept   = in_valid && in_ready;

  // Each accepted item reserves a slot in both queues until that queue releases it
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      list_resv <= '0;
      leaf_resv <= '0;
      job_valid <= 1'b0;
    end else begin
      list_resv <= list_resv + CW'(accept) - CW'(list_slot_free);
      leaf_resv <= leaf_resv + CW'(accept) - CW'(leaf_slot_free);
      job_valid <= accept;
    end
  end

  // Step the leaf counters on the way in
  always_ff @(posedge clk) begin
    if (accept) begin
      job_data.ray_info           <= in_data.ray_info;
      job_data.tri_id             <= in_data.tri_id;
      job_data.leaf_cnt.lnum_left <= in_data.leaf_cnt.lnum_left - 8'd1;
      job_data.leaf_cnt.lindex    <= in_data.leaf_cnt.lindex + 8'd1;
      job_data.tri_xform          <= in_data.tri_xform;
      job_data.ray                <= in_data.ray;
    end
  end

  // A queue may only release what was reserved
  a_resv_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    !((list_resv == '0) && list_slot_free) && !((leaf_resv == '0) && leaf_slot_free));

endmodule

`default_nettype wire

/* hdl/isect_math.sv */
// --------------------------------------------------------------------------
// No stall input, one item per cycle. No max distance test, results unscaled
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "isect_macros.svh"

module isect_math
  import isect_geom_pkg::*;
  import isect_flow_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       job_valid,
  input  isect_job_t job_data,
  output logic       exit_valid,
  output logic       list_keep,
  output logic       leaf_keep,
  output list_msg_t  list_item,
  output leaf_msg_t  leaf_item
);

  typedef struct packed {
    ray_info_t ray_info;
    tri_id_t   tri_id;
    leaf_cnt_t leaf_cnt;
  } tag_t;

  logic [`ISECT_MATH_LAT-1:0] vld;
  tag_t  tag_s1, tag_s2, tag_s3;

  fix_t  mrow [3][4];
  fix_t  org [3];
  fix_t  dir [3];

  wide_t po_s1 [3][3];
  wide_t pd_s1 [3][3];
  fix_t  tr_s1 [3];

  wide_t o_sum [3];
  wide_t d_sum [3];
  fix_t  op_s2 [3];
  fix_t  dp_s2 [3];

  fix_t  ox_s3, oy_s3, dx_s3, dy_s3;
  fix_t  tnum_s3, tden_s3;

  wide_t u_w, v_w;
  wide_t tnum_sc, tden_sc, eps_term;
  logic  hit_w;

  always_comb begin
    mrow[0] = '{job_data.tri_xform.r0.m0, job_data.tri_xform.r0.m1,
                job_data.tri_xform.r0.m2, job_data.tri_xform.r0.translate};
    mrow[1] = '{job_data.tri_xform.r1.m0, job_data.tri_xform.r1.m1,
                job_data.tri_xform.r1.m2, job_data.tri_xform.r1.translate};
    mrow[2] = '{job_data.tri_xform.r2.m0, job_data.tri_xform.r2.m1,
                job_data.tri_xform.r2.m2, job_data.tri_xform.r2.translate};
    org = '{job_data.ray.origin.x, job_data.ray.origin.y, job_data.ray.origin.z};
    dir = '{job_data.ray.dir.x, job_data.ray.dir.y, job_data.ray.dir.z};
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld <= '0;
    end else begin
      vld <= {vld[`ISECT_MATH_LAT-2:0], job_valid};
    end
  end

  // Stage 1, row products
  always_ff @(posedge clk) begin
    for (int i = 0; i < 3; i++) begin
      for (int j = 0; j < 3; j++) begin
        po_s1[i][j] <= wide_t'(mrow[i][j]) * wide_t'(org[j]);
        pd_s1[i][j] <= wide_t'(mrow[i][j]) * wide_t'(dir[j]);
      end
      tr_s1[i] <= mrow[i][3];
    end
    tag_s1 <= '{job_data.ray_info, job_data.tri_id, job_data.leaf_cnt};
  end

  // Stage 2, products are Q16.16 so translate is aligned before the add
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      o_sum[i] = po_s1[i][0] + po_s1[i][1] + po_s1[i][2] + (wide_t'(tr_s1[i]) <<< `ISECT_FRAC);
      d_sum[i] = pd_s1[i][0] + pd_s1[i][1] + pd_s1[i][2];
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 3; i++) begin
      op_s2[i] <= fix_t'(o_sum[i] >>> `ISECT_FRAC);
      dp_s2[i] <= fix_t'(d_sum[i] >>> `ISECT_FRAC);
    end
    tag_s2 <= tag_s1;
  end

  // Stage 3, plane z = 0 with a positive denominator
  always_ff @(posedge clk) begin
    if (dp_s2[2] < 0) begin
      tden_s3 <= -dp_s2[2];
      tnum_s3 <= op_s2[2];
    end else begin
      tden_s3 <= dp_s2[2];
      tnum_s3 <= -op_s2[2];
    end
    ox_s3  <= op_s2[0];
    oy_s3  <= op_s2[1];
    dx_s3  <= dp_s2[0];
    dy_s3  <= dp_s2[1];
    tag_s3 <= tag_s2;
  end

  // Stage 4, barycentrics scaled by t_den, all tests by cross-multiplication
  always_comb begin
    u_w      = wide_t'(ox_s3) * wide_t'(tden_s3) + wide_t'(tnum_s3) * wide_t'(dx_s3);
    v_w      = wide_t'(oy_s3) * wide_t'(tden_s3) + wide_t'(tnum_s3) * wide_t'(dy_s3);
    tnum_sc  = wide_t'(tnum_s3) <<< `ISECT_FRAC;
    tden_sc  = wide_t'(tden_s3) <<< `ISECT_FRAC;
    eps_term = wide_t'(`ISECT_EPS) * wide_t'(tden_s3);
    hit_w    = (tden_s3 != 0) && (tnum_sc > eps_term) && (u_w >= 0) && (v_w >= 0) &&
               (u_w + v_w <= tden_sc);
  end

  always_ff @(posedge clk) begin
    list_item.ray_info <= tag_s3.ray_info;
    list_item.tri_id   <= tag_s3.tri_id;
    list_item.hit      <= hit_w;
    list_item.is_last  <= (tag_s3.leaf_cnt.lnum_left == 8'd0);
    list_item.t_num    <= tnum_s3;
    list_item.t_den    <= tden_s3;
    list_item.u_num    <= u_w;
    list_item.v_num    <= v_w;
    leaf_item.ray_info <= tag_s3.ray_info;
    leaf_item.leaf_cnt <= tag_s3.leaf_cnt;
  end

  assign exit_valid = vld[`ISECT_MATH_LAT-1];
  assign list_keep  = list_item.hit || list_item.is_last;
  assign leaf_keep  = !list_item.is_last;

endmodule

`default_nettype wire

/* hdl/isect_out_queue.sv */
// --------------------------------------------------------------------------
// Upstream reservations keep writes within depth. Releases may lag one cycle
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "isect_macros.svh"

module isect_out_queue #(
  parameter int MSG_W = 32
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  input  logic             in_keep,
  input  logic [MSG_W-1:0] in_msg,
  output logic             slot_free,
  output logic             out_valid,
  output logic [MSG_W-1:0] out_msg,
  input  logic             credit_in
);

  localparam int AW = $clog2(`ISECT_QDEPTH);
  localparam int CW = AW + 1;
  localparam int KW = $clog2(`ISECT_CREDITS) + 1;

  logic [MSG_W-1:0] mem [`ISECT_QDEPTH];
  logic [AW-1:0]    wr_ptr, rd_ptr;
  logic [CW-1:0]    count;
  logic [KW-1:0]    credit;
  logic [CW-1:0]    free_pend;
  logic [1:0]       free_ev;
  logic             wr, pop;

  assign wr  = in_valid && in_keep;
  assign pop = (count != '0) && (credit != '0);

  // A dropped item and a pop can both release in one cycle, the extra one waits
  assign free_ev   = {1'b0, in_valid && !in_keep} + {1'b0, pop};
  assign slot_free = (free_pend != '0) || (free_ev != 2'd0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      credit    <= KW'(`ISECT_CREDITS);
      free_pend <= '0;
      out_valid <= 1'b0;
    end else begin
      // Pointers wrap on their own
      if (wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count     <= count + CW'(wr) - CW'(pop);
      credit    <= credit + KW'(credit_in) - KW'(pop);
      free_pend <= free_pend + CW'(free_ev) - CW'(slot_free);
      out_valid <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_ptr] <= in_msg;
    end
    if (pop) begin
      out_msg <= mem[rd_ptr];
    end
  end

  a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
    wr |-> (count < CW'(`ISECT_QDEPTH)));

  // Downstream returns no more than it was granted
  a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
    credit <= KW'(`ISECT_CREDITS));

endmodule

`default_nettype wire

/* hdl/isect_unit.sv */
// --------------------------------------------------------------------------
// Input is valid/ready, both outputs are credit based and keep input order
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module isect_unit
  import isect_flow_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  input  icache_to_isect_t in_data,
  output logic             in_ready,
  output logic             list_valid,
  output list_msg_t        list_data,
  input  logic             list_credit,
  output logic             leaf_valid,
  output leaf_msg_t        leaf_data,
  input  logic             leaf_credit
);

  logic       list_slot_free, leaf_slot_free;
  logic       job_valid;
  isect_job_t job_data;
  logic       exit_valid, list_keep, leaf_keep;
  list_msg_t  list_item;
  leaf_msg_t  leaf_item;

  isect_issue u_issue (
    .clk, .rst_n,
    .in_valid, .in_data, .in_ready,
    .list_slot_free, .leaf_slot_free,
    .job_valid, .job_data
  );

  isect_math u_math (
    .clk, .rst_n,
    .job_valid, .job_data,
    .exit_valid, .list_keep, .leaf_keep,
    .list_item, .leaf_item
  );

  // Hits and last-triangle reports
  isect_out_queue #(.MSG_W($bits(list_msg_t))) list_q (
    .clk, .rst_n,
    .in_valid(exit_valid), .in_keep(list_keep), .in_msg(list_item),
    .slot_free(list_slot_free),
    .out_valid(list_valid), .out_msg(list_data), .credit_in(list_credit)
  );

  // Next-triangle fetch requests
  isect_out_queue #(.MSG_W($bits(leaf_msg_t))) leaf_q (
    .clk, .rst_n,
    .in_valid(exit_valid), .in_keep(leaf_keep), .in_msg(leaf_item),
    .slot_free(leaf_slot_free),
    .out_valid(leaf_valid), .out_msg(leaf_data), .credit_in(leaf_credit)
  );

endmodule

`default_nettype wire

/* tb/isect_unit_tb.sv */
// --------------------------------------------------------------------------
// Expected values follow the Q8.8 rules of the unit
// Credits return 1 to 4 cycles after delivery
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "isect_macros.svh"

module isect_unit_tb
  import isect_geom_pkg::*;
  import isect_flow_pkg::*;
();

  localparam int SCALE = 1 << `ISECT_FRAC;
  localparam int WAIT_LIMIT = 600;

  typedef struct packed {
    list_msg_t list;
    leaf_msg_t leaf;
    logic      list_keep;
    logic      leaf_keep;
  } expect_t;

  logic             clk;
  logic             rst_n;
  logic             in_valid;
  icache_to_isect_t in_data;
  logic             in_ready;
  logic             list_valid;
  list_msg_t        list_data;
  logic             list_credit;
  logic             leaf_valid;
  leaf_msg_t        leaf_data;
  logic             leaf_credit;

  // Expected messages in input order for the comparing process
  list_msg_t   list_exp [$];
  leaf_msg_t   leaf_exp [$];
  int          list_due [$];
  int          leaf_due [$];
  int          list_rd;
  int          leaf_rd;
  int          list_count;
  int          leaf_count;
  int          not_ready_count;
  int          cmp_errors;
  int          cmp_checks;
  int          tb_errors;
  int          tb_checks;
  int          test_num;
  int          failed_tests;
  int          test_err_base;
  int          hold_base;
  int          list_base;
  int          leaf_base;
  int          gap;
  int          cycle;
  logic [31:0] stim_seed;
  logic [31:0] credit_seed;
  logic        hold_list;
  logic        random_credit;
  list_msg_t   last_list;
  leaf_msg_t   last_leaf;

  isect_unit DUT (
    .clk, .rst_n, .in_valid, .in_data, .in_ready,
    .list_valid, .list_data, .list_credit,
    .leaf_valid, .leaf_data, .leaf_credit
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [15:0] lcg_next(inout logic [31:0] s);
    s = s * 32'd1664525 + 32'd1013904223;
    return s[31:16];
  endfunction

  function automatic int rand_range(inout logic [31:0] s, input int lo, input int hi);
    int r;
    r = int'({16'h0000, lcg_next(s)});
    return lo + (r % (hi - lo + 1));
  endfunction

  // Q16.16 sum of one row shifted back to Q8.8
  function automatic fix_t apply_row(input xform_row_t r, input vec3_t p, input logic add_tr);
    wide_t acc;
    acc = wide_t'(r.m0) * wide_t'(p.x) + wide_t'(r.m1) * wide_t'(p.y) +
          wide_t'(r.m2) * wide_t'(p.z);
    if (add_tr) begin
      acc = acc + (wide_t'(r.translate) <<< `ISECT_FRAC);
    end
    return fix_t'(acc >>> `ISECT_FRAC);
  endfunction

  function automatic expect_t reference(input icache_to_isect_t it);
    expect_t e;
    fix_t    ox, oy, oz, dx, dy, dz, tn, td;
    wide_t   u, v;
    logic    hit;
    ox = apply_row(it.tri_xform.r0, it.ray.origin, 1'b1);
    oy = apply_row(it.tri_xform.r1, it.ray.origin, 1'b1);
    oz = apply_row(it.tri_xform.r2, it.ray.origin, 1'b1);
    dx = apply_row(it.tri_xform.r0, it.ray.dir, 1'b0);
    dy = apply_row(it.tri_xform.r1, it.ray.dir, 1'b0);
    dz = apply_row(it.tri_xform.r2, it.ray.dir, 1'b0);
    // Denominator always made positive
    if (dz < 0) begin
      td = -dz;
      tn = oz;
    end else begin
      td = dz;
      tn = -oz;
    end
    u = wide_t'(ox) * wide_t'(td) + wide_t'(tn) * wide_t'(dx);
    v = wide_t'(oy) * wide_t'(td) + wide_t'(tn) * wide_t'(dy);
    hit = (td != 0) && (wide_t'(tn) * wide_t'(SCALE) > wide_t'(`ISECT_EPS) * wide_t'(td)) &&
          (u >= 0) && (v >= 0) && (u + v <= wide_t'(td) * wide_t'(SCALE));
    e.leaf.ray_info           = it.ray_info;
    e.leaf.leaf_cnt.lnum_left = it.leaf_cnt.lnum_left - 8'd1;
    e.leaf.leaf_cnt.lindex    = it.leaf_cnt.lindex + 8'd1;
    e.list.ray_info = it.ray_info;
    e.list.tri_id   = it.tri_id;
    e.list.hit      = hit;
    e.list.is_last  = (e.leaf.leaf_cnt.lnum_left == 8'd0);
    e.list.t_num    = tn;
    e.list.t_den    = td;
    e.list.u_num    = u;
    e.list.v_num    = v;
    e.list_keep     = hit || e.list.is_last;
    e.leaf_keep     = !e.list.is_last;
    return e;
  endfunction

  // Identity transform with the ray along z only
  function automatic icache_to_isect_t make_item(input int tag, input int ox, input int oy,
                                                 input int oz, input int dz, input int lnum);
    icache_to_isect_t it;
    it = '0;
    it.ray_info           = ray_info_t'(tag);
    it.tri_id             = tri_id_t'(tag + 100);
    it.leaf_cnt.lnum_left = 8'(lnum);
    it.leaf_cnt.lindex    = 8'(tag);
    it.tri_xform.r0.m0    = fix_t'(SCALE);
    it.tri_xform.r1.m1    = fix_t'(SCALE);
    it.tri_xform.r2.m2    = fix_t'(SCALE);
    it.ray.origin         = '{fix_t'(ox), fix_t'(oy), fix_t'(oz)};
    it.ray.dir            = '{fix_t'(0), fix_t'(0), fix_t'(dz)};
    return it;
  endfunction

  function automatic xform_row_t random_row(input int diag);
    xform_row_t r;
    r.m0        = fix_t'(rand_range(stim_seed, -16, 15) + ((diag == 0) ? SCALE : 0));
    r.m1        = fix_t'(rand_range(stim_seed, -16, 15) + ((diag == 1) ? SCALE : 0));
    r.m2        = fix_t'(rand_range(stim_seed, -16, 15) + ((diag == 2) ? SCALE : 0));
    r.translate = fix_t'(rand_range(stim_seed, -64, 63));
    return r;
  endfunction

  // Near-identity transforms so hits and misses both occur
  function automatic icache_to_isect_t random_item(input int tag);
    icache_to_isect_t it;
    it.ray_info           = ray_info_t'(tag);
    it.tri_id             = tri_id_t'(rand_range(stim_seed, 0, 4095));
    it.leaf_cnt.lnum_left = 8'(rand_range(stim_seed, 0, 4));
    it.leaf_cnt.lindex    = 8'(rand_range(stim_seed, 0, 255));
    it.tri_xform.r0       = random_row(0);
    it.tri_xform.r1       = random_row(1);
    it.tri_xform.r2       = random_row(2);
    it.ray.origin.x       = fix_t'(rand_range(stim_seed, -32, 127));
    it.ray.origin.y       = fix_t'(rand_range(stim_seed, -32, 127));
    it.ray.origin.z       = fix_t'(rand_range(stim_seed, -128, 1023));
    it.ray.dir.x          = fix_t'(rand_range(stim_seed, -32, 31));
    it.ray.dir.y          = fix_t'(rand_range(stim_seed, -32, 31));
    it.ray.dir.z          = fix_t'(rand_range(stim_seed, -512, 127));
    return it;
  endfunction

  task automatic abort(input string why);
    $display("%s", why);
    $display("tests failed");
    $finish;
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    tb_checks++;
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      tb_errors++;
    end
  endtask

  task automatic start_test();
    test_num++;
    test_err_base = tb_errors + cmp_errors;
    list_base = list_count;
    leaf_base = leaf_count;
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = tb_errors + cmp_errors - test_err_base;
    if (errs == 0) begin
      $display("test %0d %s: ok", test_num, name);
    end else begin
      $display("test %0d %s: %0d errors", test_num, name, errs);
      failed_tests++;
    end
  endtask

  // Called 1 ns after a rising edge and returns 1 ns after the accepting edge
  task automatic send_item(input icache_to_isect_t it);
    expect_t e;
    int      waited;
    e = reference(it);
    waited = 0;
    while (!in_ready) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort("in_ready stayed low too long while sending an item");
      end
    end
    in_valid = 1'b1;
    in_data  = it;
    if (e.list_keep) begin
      list_exp.push_back(e.list);
    end
    if (e.leaf_keep) begin
      leaf_exp.push_back(e.leaf);
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((list_rd != list_exp.size()) || (leaf_rd != leaf_exp.size())) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort("expected outputs did not all arrive");
      end
    end
    // Extra cycles to catch stray outputs
    repeat (12) @(posedge clk);
    #1;
  endtask

  task automatic wait_not_ready(input int base);
    int waited;
    waited = 0;
    while (not_ready_count == base) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > 200) begin
        abort("in_ready never dropped while list credits were withheld");
      end
    end
  endtask

  // Comparing process samples mid-cycle
  initial begin
    list_rd = 0;
    leaf_rd = 0;
    list_count = 0;
    leaf_count = 0;
    not_ready_count = 0;
    cmp_errors = 0;
    cmp_checks = 0;
    last_list = '0;
    last_leaf = '0;
    forever begin
      @(negedge clk);
      if (rst_n) begin
        if (!in_ready) begin
          not_ready_count++;
        end
        if (list_valid) begin
          list_count++;
          last_list = list_data;
          if (list_rd >= list_exp.size()) begin
            $display("list output arrived with nothing expected");
            cmp_errors++;
          end else begin
            cmp_checks++;
            if (list_data !== list_exp[list_rd]) begin
              $display("FAILED list_data: got %h expected %h", list_data, list_exp[list_rd]);
              cmp_errors++;
            end
            list_rd++;
          end
        end
        if (leaf_valid) begin
          leaf_count++;
          last_leaf = leaf_data;
          if (leaf_rd >= leaf_exp.size()) begin
            $display("leaf output arrived with nothing expected");
            cmp_errors++;
          end else begin
            cmp_checks++;
            if (leaf_data !== leaf_exp[leaf_rd]) begin
              $display("FAILED leaf_data: got %h expected %h", leaf_data, leaf_exp[leaf_rd]);
              cmp_errors++;
            end
            leaf_rd++;
          end
        end
      end
    end
  end

  // Downstream model returns one credit some cycles after each delivery
  initial begin
    list_credit = 1'b0;
    leaf_credit = 1'b0;
    credit_seed = 32'd22728;
    cycle = 0;
    forever begin
      @(posedge clk);
      #1;
      cycle++;
      list_credit = 1'b0;
      leaf_credit = 1'b0;
      if (list_valid) begin
        list_due.push_back(cycle + (random_credit ? rand_range(credit_seed, 1, 4) : 2));
      end
      if (leaf_valid) begin
        leaf_due.push_back(cycle + (random_credit ? rand_range(credit_seed, 1, 4) : 2));
      end
      if (!hold_list && (list_due.size() != 0) && (list_due[0] <= cycle)) begin
        void'(list_due.pop_front());
        list_credit = 1'b1;
      end
      if ((leaf_due.size() != 0) && (leaf_due[0] <= cycle)) begin
        void'(leaf_due.pop_front());
        leaf_credit = 1'b1;
      end
    end
  end

  initial begin
    stim_seed = 32'd22728;
    tb_errors = 0;
    tb_checks = 0;
    test_num = 0;
    failed_tests = 0;
    rst_n = 1'b0;
    in_valid = 1'b0;
    in_data = '0;
    hold_list = 1'b0;
    random_credit = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    start_test();
    repeat (10) begin
      check_val("list_valid", 64'(list_valid), 64'd0);
      check_val("leaf_valid", 64'(leaf_valid), 64'd0);
      check_val("in_ready", 64'(in_ready), 64'd1);
      @(posedge clk);
      #1;
    end
    end_test("idle after reset");

    // Origin at (0.25, 0.25, 2) aimed straight down onto the triangle
    start_test();
    send_item(make_item(1, 64, 64, 512, -256, 3));
    wait_drain();
    check_val("list_valid count", 64'(list_count - list_base), 64'd1);
    check_val("leaf_valid count", 64'(leaf_count - leaf_base), 64'd1);
    check_val("list_data.hit", 64'(last_list.hit), 64'd1);
    check_val("list_data.is_last", 64'(last_list.is_last), 64'd0);
    check_val("list_data.t_num", 64'(last_list.t_num), 64'd512);
    check_val("list_data.t_den", 64'(last_list.t_den), 64'd256);
    check_val("list_data.u_num", 64'(last_list.u_num), 64'd16384);
    check_val("list_data.v_num", 64'(last_list.v_num), 64'd16384);
    check_val("leaf_data.lnum_left", 64'(last_leaf.leaf_cnt.lnum_left), 64'd2);
    check_val("leaf_data.lindex", 64'(last_leaf.leaf_cnt.lindex), 64'd2);
    end_test("straight hit");

    start_test();
    send_item(make_item(2, -128, 64, 512, -256, 3));
    send_item(make_item(3, 64, 64, 512, 256, 3));
    wait_drain();
    check_val("list_valid count", 64'(list_count - list_base), 64'd0);
    check_val("leaf_valid count", 64'(leaf_count - leaf_base), 64'd2);
    end_test("miss and away");

    // Item 4 hits and item 5 misses
    start_test();
    send_item(make_item(4, 64, 64, 512, -256, 1));
    send_item(make_item(5, -128, 64, 512, -256, 1));
    wait_drain();
    check_val("list_valid count", 64'(list_count - list_base), 64'd2);
    check_val("leaf_valid count", 64'(leaf_count - leaf_base), 64'd0);
    check_val("list_data.is_last", 64'(last_list.is_last), 64'd1);
    check_val("list_data.hit", 64'(last_list.hit), 64'd0);
    end_test("last triangle");

    start_test();
    hold_list = 1'b1;
    hold_base = list_count;
    fork
      begin
        for (int i = 0; i < 40; i++) begin
          send_item(make_item(i, 64, 64, 512, -256, 3));
        end
      end
      begin
        wait_not_ready(not_ready_count);
        repeat (10) @(posedge clk);
        #1;
        if (list_count - hold_base > `ISECT_CREDITS) begin
          $display("FAILED list_valid count: got %h expected at most %h",
                   list_count - hold_base, `ISECT_CREDITS);
          tb_errors++;
        end
        hold_list = 1'b0;
      end
    join
    wait_drain();
    end_test("list credits withheld");

    start_test();
    random_credit = 1'b1;
    for (int n = 0; n < 300; n++) begin
      gap = rand_range(stim_seed, 0, 3);
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      send_item(random_item(n));
    end
    wait_drain();
    end_test("random items");

    $display("tests %0d, failing %0d, checks %0d, errors %0d", test_num, failed_tests,
             tb_checks + cmp_checks, tb_errors + cmp_errors);
    if (tb_errors + cmp_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+hdl
hdl/isect_geom_pkg.sv
hdl/isect_flow_pkg.sv
hdl/isect_issue.sv
hdl/isect_math.sv
hdl/isect_out_queue.sv
hdl/isect_unit.sv
tb/isect_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= isect_unit_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= tb.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= all tests passed

SRCS := $(shell grep -v '^+' $(FILELIST))
INCS := $(wildcard hdl/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(INCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
